// File: adpcm_boost_stage.sv
`timescale 1ns/1ps

module adpcm_boost_stage import audio_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset,
	input  sample_t adpcm,
	input  logic    adpcm_en,
	input  logic    adpcm_boost,
	output boost_t  adpcm_mix
);

	boost_t adpcm_ext;
	boost_t adpcm_quarter;
	boost_t adpcm_next;

	assign adpcm_ext = {adpcm[15], adpcm};

	// Quarter of the sample, rounded toward minus infinity
	assign adpcm_quarter = adpcm_ext >>> 2;

	always_comb begin
		if (!adpcm_en)
			adpcm_next = '0;
		else if (adpcm_boost)
			adpcm_next = adpcm_ext + adpcm_quarter;
		else
			adpcm_next = adpcm_ext;
	end

	// Same cycle as the stereo summer, so both parts stay aligned
	always_ff @(posedge clk_sys) begin
		if (reset)
			adpcm_mix <= '0;
		else
			adpcm_mix <= adpcm_next;
	end

endmodule

// File: audio_core.sv
`timescale 1ns/1ps

module audio_core import audio_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  sample_t   cdda_l,
	input  sample_t   cdda_r,
	input  sample_t   psg_l,
	input  sample_t   psg_r,
	input  sample_t   adpcm,
	input  logic      cdda_en,
	input  logic      psg_en,
	input  logic      adpcm_en,
	input  logic      cdda_boost,
	input  logic      adpcm_boost,
	input  gain_sel_t master_gain,
	output sample_t   audio_l,
	output sample_t   audio_r
);

	mix_t   src_l;
	mix_t   src_r;
	boost_t adpcm_mix;

	// Stereo voices and ADPCM run side by side for one cycle
	stereo_source_sum source_sum_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cdda_l     (cdda_l),
		.cdda_r     (cdda_r),
		.psg_l      (psg_l),
		.psg_r      (psg_r),
		.cdda_en    (cdda_en),
		.psg_en     (psg_en),
		.cdda_boost (cdda_boost),
		.src_l      (src_l),
		.src_r      (src_r)
	);

	adpcm_boost_stage adpcm_boost_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.adpcm       (adpcm),
		.adpcm_en    (adpcm_en),
		.adpcm_boost (adpcm_boost),
		.adpcm_mix   (adpcm_mix)
	);

	audio_master_stage master_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.src_l       (src_l),
		.src_r       (src_r),
		.adpcm_mix   (adpcm_mix),
		.cdda_boost  (cdda_boost),
		.master_gain (master_gain),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

endmodule

// File: audio_master_stage.sv
`timescale 1ns/1ps

module audio_master_stage import audio_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  mix_t      src_l,
	input  mix_t      src_r,
	input  boost_t    adpcm_mix,
	input  logic      cdda_boost,
	input  gain_sel_t master_gain,
	output sample_t   audio_l,
	output sample_t   audio_r
);

	mix_t    adpcm_ext;
	mix_t    full_l;
	mix_t    full_r;
	mix_t    scaled_l;
	mix_t    scaled_r;
	sample_t top_l;
	sample_t top_r;
	sample_t dry_l;
	sample_t dry_r;
	sample_t wet_l;
	sample_t wet_r;
	logic    curve4x;

	// ADPCM is mono, the same value goes to both channels
	assign adpcm_ext = {adpcm_mix[16], adpcm_mix};

	// 5/4 stretches the three-voice sum over the whole range.
	// With CD boost the doubled voice already fills it
	function automatic mix_t scale_sum(input mix_t value, input logic keep);
		mix_t quarter;
		quarter = value >>> 2;
		if (keep)
			return value;
		return value + quarter;
	endfunction

	//////////////////////////////
	// Sum and scale
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			full_l <= '0;
			full_r <= '0;
			scaled_l <= '0;
			scaled_r <= '0;
		end else begin
			full_l <= src_l + adpcm_ext;
			full_r <= src_r + adpcm_ext;
			scaled_l <= scale_sum(full_l, cdda_boost);
			scaled_r <= scale_sum(full_r, cdda_boost);
		end
	end

	// Drop the two headroom bits
	assign top_l = scaled_l[17:2];
	assign top_r = scaled_r[17:2];

	//////////////////////////////
	// Compression
	//////////////////////////////

	// Codes 2 and 3 both pick the 4x curve
	assign curve4x = master_gain > GAIN_2X;

	dynamic_compressor comp_l_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.curve4x    (curve4x),
		.sample_in  (top_l),
		.sample_out (wet_l)
	);

	dynamic_compressor comp_r_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.curve4x    (curve4x),
		.sample_in  (top_r),
		.sample_out (wet_r)
	);

	// Dry path matches the compressor register
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dry_l <= '0;
			dry_r <= '0;
		end else begin
			dry_l <= top_l;
			dry_r <= top_r;
		end
	end

	assign audio_l = (master_gain != GAIN_NONE) ? wet_l : dry_l;
	assign audio_r = (master_gain != GAIN_NONE) ? wet_r : dry_r;

endmodule

// File: audio_pkg.sv
package audio_pkg;

	//////////////////////////////
	// Sample widths
	//////////////////////////////

	// One voice, and the final output
	typedef logic signed [15:0] sample_t;

	// ADPCM after the optional quarter boost
	typedef logic signed [16:0] boost_t;

	// Channel sum, two bits of headroom over one voice
	typedef logic signed [17:0] mix_t;

	// Master boost code from the mode levels
	typedef logic [1:0] gain_sel_t;

	//////////////////////////////
	// Compressor curves
	//////////////////////////////

	// 2x curve, steep below the knee and flat above it
	localparam int COMP1_SLOPE = 2;
	localparam int COMP1_FALL  = 4;
	localparam int COMP1_KNEE  = 14044;
	localparam int COMP1_BASE  = 28088;

	// 4x curve
	localparam int COMP2_SLOPE = 4;
	localparam int COMP2_FALL  = 8;
	localparam int COMP2_KNEE  = 7400;
	localparam int COMP2_BASE  = 29600;

	// Largest magnitude a compressed sample may reach
	localparam int COMP_CEIL = 32767;

	//////////////////////////////
	// Modes and pipeline
	//////////////////////////////

	localparam gain_sel_t GAIN_NONE = 2'd0;
	localparam gain_sel_t GAIN_2X   = 2'd1;

	// Input edge to output, in clk_sys cycles
	localparam int MIX_LATENCY = 4;

	// Range of a channel sum with CD counted twice plus PSG
	localparam int SRC_MAX = 3 * 32767;
	localparam int SRC_MIN = -3 * 32768;

endpackage

// File: dynamic_compressor.sv
`timescale 1ns/1ps

module dynamic_compressor import audio_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset,
	input  logic    curve4x,
	input  sample_t sample_in,
	output sample_t sample_out
);

	// Extra bit so that -32768 has a magnitude
	logic [16:0] mag;
	logic [16:0] knee;
	logic [16:0] base;
	logic [16:0] slope;
	logic [16:0] fall;
	logic [16:0] shaped;
	logic [15:0] level;

	assign mag = sample_in[15] ? ~{1'b1, sample_in} + 17'd1 : {1'b0, sample_in};

	//////////////////////////////
	// Curve select
	//////////////////////////////

	always_comb begin
		if (curve4x) begin
			knee = 17'(COMP2_KNEE);
			base = 17'(COMP2_BASE);
			slope = 17'(COMP2_SLOPE);
			fall = 17'(COMP2_FALL);
		end else begin
			knee = 17'(COMP1_KNEE);
			base = 17'(COMP1_BASE);
			slope = 17'(COMP1_SLOPE);
			fall = 17'(COMP1_FALL);
		end
	end

	always_comb begin
		if (mag < knee)
			shaped = mag * slope;
		else
			shaped = (mag - knee) / fall + base;
		// Near full scale the upper segment runs past 32767
		if (shaped > 17'(COMP_CEIL))
			shaped = 17'(COMP_CEIL);
		level = shaped[15:0];
	end

	//////////////////////////////
	// Sign restore
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			sample_out <= '0;
		else if (sample_in[15])
			sample_out <= ~level + 16'd1;
		else
			sample_out <= level;
	end

	// The curve is odd-symmetric, a nonzero sample keeps its sign
	a_sign_kept: assert property (@(posedge clk_sys) disable iff (reset)
		(!$past(reset) && ($past(sample_in) != 16'sd0)) |->
		(sample_out[15] == $past(sample_in[15])))
		else $error("compressor flipped sign, out=%0d", sample_out);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the audio mixer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module tb_audio_core --Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

sim_output=$(./obj_dir/Vtb_audio_core)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

# Pass only when the testbench printed its pass line
if echo "$sim_output" | grep -Fqx 'All tests passed!'; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// File: sim.f
+incdir+.
audio_pkg.sv
stereo_source_sum.sv
adpcm_boost_stage.sv
dynamic_compressor.sv
audio_master_stage.sv
audio_core.sv
tb_audio_core.sv

// File: stereo_source_sum.sv
`timescale 1ns/1ps

module stereo_source_sum import audio_pkg::*; (
	input  logic    clk_sys,
	input  logic    reset,
	input  sample_t cdda_l,
	input  sample_t cdda_r,
	input  sample_t psg_l,
	input  sample_t psg_r,
	input  logic    cdda_en,
	input  logic    psg_en,
	input  logic    cdda_boost,
	output mix_t    src_l,
	output mix_t    src_r
);

	// One channel of CD-audio and PSG, each voice gated by its enable
	function automatic mix_t chan_sum(
		input sample_t cdda,
		input sample_t psg,
		input logic    cd_on,
		input logic    psg_on,
		input logic    cd_twice
	);
		mix_t cdda_ext;
		mix_t psg_ext;
		mix_t sum;
		cdda_ext = {{2{cdda[15]}}, cdda};
		psg_ext = {{2{psg[15]}}, psg};
		sum = '0;
		if (cd_on)
			sum = sum + cdda_ext;
		// CD boost counts the voice a second time
		if (cd_on && cd_twice)
			sum = sum + cdda_ext;
		if (psg_on)
			sum = sum + psg_ext;
		return sum;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			src_l <= '0;
			src_r <= '0;
		end else begin
			src_l <= chan_sum(cdda_l, psg_l, cdda_en, psg_en, cdda_boost);
			src_r <= chan_sum(cdda_r, psg_r, cdda_en, psg_en, cdda_boost);
		end
	end

	// Three voices at most, so the two headroom bits never wrap
	a_src_range: assert property (@(posedge clk_sys) disable iff (reset)
		(src_l <= SRC_MAX) && (src_l >= SRC_MIN) &&
		(src_r <= SRC_MAX) && (src_r >= SRC_MIN))
		else $error("source sum out of range l=%0d r=%0d", src_l, src_r);

endmodule

// File: tb_audio_model.svh
`ifndef TB_AUDIO_MODEL_SVH
`define TB_AUDIO_MODEL_SVH

//////////////////////////////
// Source stages
//////////////////////////////

function automatic mix_t model_src(
	input sample_t cdda,
	input sample_t psg,
	input logic    cdda_en,
	input logic    psg_en,
	input logic    cdda_boost
);
	mix_t sum;
	sum = '0;
	if (cdda_en)
		sum = sum + mix_t'(cdda);
	if (cdda_en && cdda_boost)
		sum = sum + mix_t'(cdda);
	if (psg_en)
		sum = sum + mix_t'(psg);
	return sum;
endfunction

function automatic boost_t model_adpcm(
	input sample_t adpcm,
	input logic    adpcm_en,
	input logic    adpcm_boost
);
	boost_t ext;
	ext = boost_t'(adpcm);
	if (!adpcm_en)
		return '0;
	if (adpcm_boost)
		return ext + (ext >>> 2);
	return ext;
endfunction

//////////////////////////////
// Master stage
//////////////////////////////

function automatic sample_t model_compress(input sample_t value, input logic curve4x);
	int mag;
	int lvl;
	int knee;
	mag = (value < 0) ? -int'(value) : int'(value);
	knee = curve4x ? COMP2_KNEE : COMP1_KNEE;
	if (mag < knee)
		lvl = mag * (curve4x ? COMP2_SLOPE : COMP1_SLOPE);
	else
		lvl = (mag - knee) / (curve4x ? COMP2_FALL : COMP1_FALL) +
			(curve4x ? COMP2_BASE : COMP1_BASE);
	if (lvl > COMP_CEIL)
		lvl = COMP_CEIL;
	return sample_t'((value < 0) ? -lvl : lvl);
endfunction

function automatic sample_t model_channel(
	input mix_t      src,
	input boost_t    adpcm_v,
	input logic      cdda_boost,
	input gain_sel_t master_gain
);
	mix_t    full;
	mix_t    scaled;
	sample_t top;
	full = src + mix_t'(adpcm_v);
	scaled = cdda_boost ? full : full + (full >>> 2);
	top = scaled[17:2];
	if (master_gain != GAIN_NONE)
		return model_compress(top, master_gain > GAIN_2X);
	return top;
endfunction

`endif

// File: tb_audio_core.sv
`timescale 1ns/1ps

module tb_audio_core import audio_pkg::*; ();

	`include "tb_audio_model.svh"

	localparam int CLK_HALF = 50;
	localparam int CLK_PERIOD = 2 * CLK_HALF;
	localparam logic [31:0] RAND_SEED = 32'hfcfb6187;
	localparam int FLOW_SETS = 10;

	logic      clk_sys;
	logic      reset;
	sample_t   cdda_l;
	sample_t   cdda_r;
	sample_t   psg_l;
	sample_t   psg_r;
	sample_t   adpcm;
	logic      cdda_en;
	logic      psg_en;
	logic      adpcm_en;
	logic      cdda_boost;
	logic      adpcm_boost;
	gain_sel_t master_gain;
	sample_t   audio_l;
	sample_t   audio_r;

	int errors;
	int checks;
	int edge_count;

	audio_core dut_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cdda_l      (cdda_l),
		.cdda_r      (cdda_r),
		.psg_l       (psg_l),
		.psg_r       (psg_r),
		.adpcm       (adpcm),
		.cdda_en     (cdda_en),
		.psg_en      (psg_en),
		.adpcm_en    (adpcm_en),
		.cdda_boost  (cdda_boost),
		.adpcm_boost (adpcm_boost),
		.master_gain (master_gain),
		.audio_l     (audio_l),
		.audio_r     (audio_r)
	);

	// Rising edges are counted so the waits can poll between edges
	always begin
		#(CLK_HALF);
		clk_sys = ~clk_sys;
		if (clk_sys)
			edge_count++;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Polls run half a ns off the clock grid and return 1 ns after the last edge
	task automatic wait_edges(input int count);
		int target;
		int spins;
		int limit;
		target = edge_count + count;
		limit = (count + 2) * CLK_PERIOD;
		spins = 0;
		#0.5;
		while (edge_count < target && spins < limit) begin
			#1;
			spins++;
		end
		if (edge_count < target) begin
			$display("Timed out waiting for %0d clock edges at %0t", count, $time);
			$display("Test failures found");
			$finish;
		end else begin
			#0.5;
		end
	endtask

	task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("[ERROR] %0t %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic set_mode(
		input logic      cd_on,
		input logic      psg_on,
		input logic      ad_on,
		input logic      cd_twice,
		input logic      ad_quarter,
		input gain_sel_t gain
	);
		cdda_en = cd_on;
		psg_en = psg_on;
		adpcm_en = ad_on;
		cdda_boost = cd_twice;
		adpcm_boost = ad_quarter;
		master_gain = gain;
	endtask

	function automatic sample_t expect_channel(input sample_t cd, input sample_t pg,
		input sample_t ad);
		return model_channel(model_src(cd, pg, cdda_en, psg_en, cdda_boost),
			model_adpcm(ad, adpcm_en, adpcm_boost), cdda_boost, master_gain);
	endfunction

	function automatic sample_t rand_sample();
		return sample_t'($urandom);
	endfunction

	// One sample set through the whole pipeline
	task automatic mix_one(input sample_t cl, input sample_t cr, input sample_t pl,
		input sample_t pr, input sample_t ad);
		sample_t exp_l;
		sample_t exp_r;
		cdda_l = cl;
		cdda_r = cr;
		psg_l = pl;
		psg_r = pr;
		adpcm = ad;
		exp_l = expect_channel(cl, pl, ad);
		exp_r = expect_channel(cr, pr, ad);
		wait_edges(MIX_LATENCY);
		check_sample("audio_l", exp_l, audio_l);
		check_sample("audio_r", exp_r, audio_r);
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic test_reset_idle();
		check_sample("audio_l", 16'sd0, audio_l);
		check_sample("audio_r", 16'sd0, audio_r);
		set_mode(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, GAIN_NONE);
		repeat (4)
			mix_one(rand_sample(), rand_sample(), rand_sample(), rand_sample(), rand_sample());
		check_sample("audio_l", 16'sd0, audio_l);
		check_sample("audio_r", 16'sd0, audio_r);
	endtask

	task automatic test_psg_only();
		set_mode(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, GAIN_NONE);
		mix_one(16'sd0, 16'sd0, -16'sd32768, -16'sd32768, 16'sd0);
		mix_one(16'sd0, 16'sd0, 16'sd32767, -16'sd32768, 16'sd0);
		repeat (6)
			mix_one(rand_sample(), rand_sample(), rand_sample(), rand_sample(), rand_sample());
	endtask

	task automatic test_cdda_boost();
		set_mode(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, GAIN_NONE);
		mix_one(16'sd12000, -16'sd9000, 16'sd0, 16'sd0, 16'sd0);
		mix_one(-16'sd32768, 16'sd32767, 16'sd0, 16'sd0, 16'sd0);
		// Same inputs with the voice gated off
		set_mode(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, GAIN_NONE);
		mix_one(16'sd12000, -16'sd9000, 16'sd0, 16'sd0, 16'sd0);
		check_sample("audio_l", 16'sd0, audio_l);
		check_sample("audio_r", 16'sd0, audio_r);
	endtask

	task automatic test_adpcm();
		sample_t ad;
		ad = rand_sample();
		set_mode(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, GAIN_NONE);
		mix_one(rand_sample(), rand_sample(), rand_sample(), rand_sample(), ad);
		set_mode(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, GAIN_NONE);
		mix_one(rand_sample(), rand_sample(), rand_sample(), rand_sample(), ad);
		mix_one(16'sd0, 16'sd0, 16'sd0, 16'sd0, -16'sd32768);
	endtask

	// CD counted twice plus PSG at twice the level gives four times top
	task automatic compress_point(input int top);
		mix_one(sample_t'(top), sample_t'(-top), sample_t'(2 * top), sample_t'(-2 * top), 16'sd0);
	endtask

	task automatic test_compression();
		gain_sel_t gain;
		int        points[10];
		points = '{500, 1000, 7399, 7400, 7401, 12000, 14043, 14044, 14045, 15000};
		for (int g = 1; g <= 2; g++) begin
			gain = gain_sel_t'(g);
			set_mode(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, gain);
			foreach (points[i])
				compress_point(points[i]);
			// Full scale on all voices reaches the ceiling
			set_mode(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, gain);
			mix_one(16'sd32767, 16'sd32767, 16'sd32767, 16'sd32767, 16'sd32767);
			mix_one(-16'sd32768, -16'sd32768, -16'sd32768, -16'sd32768, -16'sd32768);
		end
	endtask

	task automatic test_pipeline_flow();
		sample_t exp_l[FLOW_SETS];
		sample_t exp_r[FLOW_SETS];
		sample_t cl;
		sample_t cr;
		sample_t pl;
		sample_t pr;
		sample_t ad;
		set_mode(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, GAIN_2X);
		for (int c = 0; c < FLOW_SETS + MIX_LATENCY; c++) begin
			if (c >= MIX_LATENCY) begin
				check_sample("audio_l", exp_l[c - MIX_LATENCY], audio_l);
				check_sample("audio_r", exp_r[c - MIX_LATENCY], audio_r);
			end
			if (c < FLOW_SETS) begin
				// Half level keeps the 5/4 scaled sum inside the headroom
				cl = rand_sample() >>> 1;
				cr = rand_sample() >>> 1;
				pl = rand_sample() >>> 1;
				pr = rand_sample() >>> 1;
				ad = rand_sample() >>> 1;
				cdda_l = cl;
				cdda_r = cr;
				psg_l = pl;
				psg_r = pr;
				adpcm = ad;
				exp_l[c] = expect_channel(cl, pl, ad);
				exp_r[c] = expect_channel(cr, pr, ad);
			end
			wait_edges(1);
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		clk_sys = 1'b0;
		reset = 1'b1;
		errors = 0;
		checks = 0;
		edge_count = 0;
		cdda_l = '0;
		cdda_r = '0;
		psg_l = '0;
		psg_r = '0;
		adpcm = '0;
		set_mode(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, GAIN_NONE);
		void'($urandom(RAND_SEED));
		wait_edges(2);
		reset = 1'b0;

		test_reset_idle();
		test_psg_only();
		test_cdda_boost();
		test_adpcm();
		test_compression();
		test_pipeline_flow();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule
